/* mips_pipe.f */
src/mips_pkg.sv
src/fetch_stage.sv
src/hazard_unit.sv
src/decode_stage.sv
src/execute_stage.sv
src/mem_wb_stage.sv
src/mips_core.sv
bench/tb_mips_core.sv

/* Makefile */
SOURCES := $(wildcard src/*.sv) bench/tb_mips_core.sv

obj_dir/Vtb_mips_core: mips_pipe.f $(SOURCES)
	verilator --binary --assert -Wno-fatal --top-module tb_mips_core -f mips_pipe.f

run: obj_dir/Vtb_mips_core
	./obj_dir/Vtb_mips_core

clean:
	rm -rf obj_dir

.PHONY: run clean

/* bench/tb_mips_core.sv */
//##############################
// Testbench for the MIPS core
// memory models, hand-assembled
// program and ordered store checks
//##############################
`timescale 1ns/1ns
`default_nettype none

module tb_mips_core;

	localparam int TIMEOUT_CYCLES = 200; // about 3x the worst-case run
	localparam int IMEM_WORDS = 64;

	localparam logic [5:0] OP_R = 6'd0;
	localparam logic [5:0] OP_BEQ = 6'd4;
	localparam logic [5:0] OP_BNE = 6'd5;
	localparam logic [5:0] OP_ADDI = 6'd8;
	localparam logic [5:0] OP_SLTI = 6'd10;
	localparam logic [5:0] OP_ANDI = 6'd12;
	localparam logic [5:0] OP_ORI = 6'd13;
	localparam logic [5:0] OP_LUI = 6'd15;
	localparam logic [5:0] OP_LW = 6'd35;
	localparam logic [5:0] OP_SW = 6'd43;

	logic clk;
	logic rst_n;
	logic [31:0] imem_addr;
	logic [31:0] imem_data;
	logic [12:0] dmem_addr;
	logic [31:0] dmem_wdata;
	logic dmem_we;
	logic dmem_re;
	logic [31:0] dmem_rdata;

	logic [31:0] imem [IMEM_WORDS];
	logic [31:0] dmem [8192];
	logic [12:0] exp_addr_q [$];
	logic [31:0] exp_data_q [$];
	logic [12:0] exp_load_q [$];
	int cycle_count;

	mips_core dut_i (
		.clk(clk),
		.rst_n(rst_n),
		.imem_addr(imem_addr),
		.imem_data(imem_data),
		.dmem_addr(dmem_addr),
		.dmem_wdata(dmem_wdata),
		.dmem_we(dmem_we),
		.dmem_re(dmem_re),
		.dmem_rdata(dmem_rdata)
	);

	// both memories answer in the same cycle
	assign imem_data = (imem_addr < IMEM_WORDS) ? imem[imem_addr[5:0]] : 32'd0;
	assign dmem_rdata = dmem[dmem_addr];

	always @(posedge clk)
	begin
		if (dmem_we)
			dmem[dmem_addr] <= dmem_wdata;
	end

	always #10 clk = ~clk;

	function automatic logic [31:0] enc_r(input logic [5:0] fn, input logic [4:0] rd,
		input logic [4:0] rs, input logic [4:0] rt, input logic [4:0] sh);
		return {OP_R, rs, rt, rd, sh, fn};
	endfunction

	function automatic logic [31:0] enc_i(input logic [5:0] op, input logic [4:0] rt,
		input logic [4:0] rs, input logic [15:0] imm);
		return {op, rs, rt, imm};
	endfunction

	task automatic abort_run(input string why);
		$display("%s", why);
		$display("*** FAILED ***");
		$fatal(1, "simulation stopped on error");
	endtask

	task automatic expect_store(input logic [12:0] addr, input logic [31:0] data);
		exp_addr_q.push_back(addr);
		exp_data_q.push_back(data);
	endtask

	task automatic check_idle_outputs();
		assert (dmem_we == 1'b0)
		else abort_run($sformatf("mismatch dmem_we: got %h, expected 0", dmem_we));
		assert (dmem_re == 1'b0)
		else abort_run($sformatf("mismatch dmem_re: got %h, expected 0", dmem_re));
		assert (imem_addr == 32'd0)
		else abort_run($sformatf("mismatch imem_addr: got %h, expected 00000000", imem_addr));
	endtask

	task automatic load_program();
		for (int i = 0; i < IMEM_WORDS; i++)
			imem[i] = 32'd0; // sll r0 no-op
		imem[0] = enc_i(OP_ADDI, 1, 0, 16'd5); // r1 = 5
		imem[1] = enc_i(OP_ADDI, 2, 0, 16'hFFFD); // r2 = -3
		imem[2] = enc_i(OP_ORI, 3, 0, 16'h8001); // zero-extended
		imem[3] = enc_i(OP_LUI, 4, 0, 16'h1234);
		imem[4] = enc_i(OP_ANDI, 5, 2, 16'h8F0F); // sign-extended
		imem[5] = enc_i(OP_SLTI, 6, 2, 16'hFFFE); // -3 < -2
		for (int i = 0; i < 6; i++)
			imem[6 + i] = enc_i(OP_SW, 5'(1 + i), 0, 16'(16'h40 + i));
		imem[12] = enc_r(6'h20, 7, 1, 2, 0); // add
		imem[13] = enc_r(6'h22, 8, 7, 1, 0); // sub, r7 at distance one
		imem[14] = enc_r(6'h24, 9, 8, 3, 0); // and
		imem[15] = enc_r(6'h25, 10, 4, 9, 0); // or
		imem[16] = enc_r(6'h26, 11, 10, 5, 0); // xor
		imem[17] = enc_r(6'h27, 12, 9, 1, 0); // nor
		imem[18] = enc_r(6'h2a, 13, 8, 1, 0); // slt -3 < 5
		imem[19] = enc_r(6'h00, 14, 0, 10, 4); // sll 4
		imem[20] = enc_r(6'h02, 15, 0, 14, 8); // srl 8
		for (int i = 0; i < 9; i++)
			imem[21 + i] = enc_i(OP_SW, 5'(7 + i), 0, 16'(16'h46 + i));
		imem[30] = enc_i(OP_ADDI, 16, 1, 16'd7);
		imem[31] = enc_i(OP_SW, 16, 0, 16'h004F); // store data forwarded
		imem[32] = enc_i(OP_ADDI, 17, 0, 16'h0060);
		imem[33] = enc_i(OP_SW, 16, 17, 16'h0000); // base forwarded
		imem[34] = enc_r(6'h20, 18, 16, 16, 0);
		imem[35] = enc_i(OP_ADDI, 19, 0, 16'd1);
		imem[36] = enc_r(6'h22, 20, 18, 19, 0); // distances two and one
		imem[37] = enc_i(OP_SW, 20, 0, 16'h0050);
		imem[38] = enc_i(OP_LW, 21, 0, 16'h0100);
		imem[39] = enc_r(6'h20, 22, 21, 1, 0); // load-use
		imem[40] = enc_i(OP_SW, 22, 0, 16'h0051);
		imem[41] = enc_i(OP_LW, 23, 0, 16'h0101);
		imem[42] = enc_i(OP_SW, 23, 0, 16'h0052); // load then store of it
		imem[43] = enc_i(OP_BEQ, 1, 1, 16'd1); // taken, skips 44
		imem[44] = enc_i(OP_SW, 0, 0, 16'h007F); // wrong path
		imem[45] = enc_i(OP_BNE, 1, 1, 16'd1); // not taken
		imem[46] = enc_i(OP_SW, 1, 0, 16'h0053);
		imem[47] = enc_i(OP_ADDI, 24, 0, 16'd5);
		imem[48] = enc_i(OP_BEQ, 1, 24, 16'd1); // just computed, taken
		imem[49] = enc_i(OP_SW, 0, 0, 16'h007E); // wrong path
		imem[50] = enc_i(OP_ADDI, 26, 0, 16'd5);
		imem[51] = enc_i(OP_BNE, 1, 26, 16'd1); // just computed, not taken
		imem[52] = enc_i(OP_SW, 26, 0, 16'h0054);
		imem[53] = enc_i(OP_LW, 25, 0, 16'h0100);
		imem[54] = enc_i(OP_BEQ, 21, 25, 16'd1); // just loaded, taken
		imem[55] = enc_i(OP_SW, 0, 0, 16'h007D); // wrong path
		imem[56] = enc_i(OP_SW, 25, 0, 16'h0055);
		imem[57] = enc_i(OP_SW, 29, 0, 16'h0056); // stack pointer reset value
		imem[58] = enc_i(OP_BEQ, 0, 0, 16'hFFFF); // spin here
	endtask

	task automatic load_data();
		for (int i = 0; i < 8192; i++)
			dmem[i] = {16'(i) ^ 16'hC3A5, ~16'(i)};
		dmem[13'h100] = 32'h00001234;
		dmem[13'h101] = 32'hFFFFFFF0;
	endtask

	task automatic load_expected();
		expect_store(13'h040, 32'h00000005);
		expect_store(13'h041, 32'hFFFFFFFD);
		expect_store(13'h042, 32'h00008001);
		expect_store(13'h043, 32'h12340000);
		expect_store(13'h044, 32'hFFFF8F0D);
		expect_store(13'h045, 32'h00000001);
		expect_store(13'h046, 32'h00000002);
		expect_store(13'h047, 32'hFFFFFFFD);
		expect_store(13'h048, 32'h00008001);
		expect_store(13'h049, 32'h12348001);
		expect_store(13'h04A, 32'hEDCB0F0C);
		expect_store(13'h04B, 32'hFFFF7FFA);
		expect_store(13'h04C, 32'h00000001);
		expect_store(13'h04D, 32'h23480010);
		expect_store(13'h04E, 32'h00234800);
		expect_store(13'h04F, 32'h0000000C);
		expect_store(13'h060, 32'h0000000C);
		expect_store(13'h050, 32'h00000017);
		expect_store(13'h051, 32'h00001239);
		expect_store(13'h052, 32'hFFFFFFF0);
		expect_store(13'h053, 32'h00000005);
		expect_store(13'h054, 32'h00000005);
		expect_store(13'h055, 32'h00001234);
		expect_store(13'h056, 32'h00001FFF);
		exp_load_q.push_back(13'h100);
		exp_load_q.push_back(13'h101);
		exp_load_q.push_back(13'h100);
	endtask

	initial
	begin
		clk = 1'b0;
		rst_n = 1'b0;
		cycle_count = 0;
		load_program();
		load_data();
		load_expected();
		repeat (5) @(posedge clk);
		#2 rst_n = 1'b1;
		@(negedge clk);
		check_idle_outputs(); // first cycle out of reset
		@(negedge clk);
		assert (imem_addr == 32'd1)
		else abort_run($sformatf("mismatch imem_addr: got %h, expected 00000001", imem_addr));
	end

	always @(negedge clk)
	begin
		if (!rst_n)
			check_idle_outputs();
	end

	// loads sampled mid-cycle, in program order
	always @(negedge clk)
	begin
		if (rst_n && dmem_re)
		begin
			assert (exp_load_q.size() != 0)
			else abort_run("a load reached data memory after all expected loads");
			assert (dmem_addr == exp_load_q[0])
			else abort_run($sformatf("mismatch dmem_addr: got %h, expected %h",
				dmem_addr, exp_load_q[0]));
			void'(exp_load_q.pop_front());
		end
	end

	// stores sampled mid-cycle, in program order
	always @(negedge clk)
	begin
		if (rst_n && dmem_we)
		begin
			assert (dmem_addr == exp_addr_q[0])
			else abort_run($sformatf("mismatch dmem_addr: got %h, expected %h",
				dmem_addr, exp_addr_q[0]));
			assert (dmem_wdata == exp_data_q[0])
			else abort_run($sformatf("mismatch dmem_wdata: got %h, expected %h",
				dmem_wdata, exp_data_q[0]));
			void'(exp_addr_q.pop_front());
			void'(exp_data_q.pop_front());
			if (exp_addr_q.size() == 0)
			begin
				if (exp_load_q.size() == 0)
				begin
					$display("*** PASSED ***");
					$finish;
				end
				else
					abort_run($sformatf("%0d expected loads never reached data memory",
						exp_load_q.size()));
			end
		end
	end

	always @(posedge clk)
	begin
		cycle_count <= cycle_count + 1;
		if (cycle_count == TIMEOUT_CYCLES)
			abort_run($sformatf("timeout after %0d cycles, %0d expected stores never arrived",
				cycle_count, exp_addr_q.size()));
	end

endmodule

`default_nettype wire

/* src/mips_core.sv */
//##############################
// MIPS pipeline core
// five stages plus hazard unit,
// external memory ports
//##############################
`timescale 1ns/1ns
`default_nettype none

module mips_core (
	input wire clk,
	input wire rst_n,
	output mips_pkg::pc_t imem_addr,
	input wire mips_pkg::word_t imem_data,
	output logic [mips_pkg::DMEM_AW-1:0] dmem_addr,
	output mips_pkg::word_t dmem_wdata,
	output logic dmem_we,
	output logic dmem_re,
	input wire mips_pkg::word_t dmem_rdata
);

	logic hold;
	logic bubble;
	logic flush;
	logic branch_taken;
	mips_pkg::pc_t branch_target;
	mips_pkg::word_t ifid_instr;
	mips_pkg::pc_t ifid_pc_next;

	logic idex_reg_write;
	logic idex_mem_read;
	logic idex_mem_write;
	logic idex_mem_to_reg;
	logic idex_alu_src;
	mips_pkg::alu_op_e idex_alu_op;
	mips_pkg::word_t idex_rs_data;
	mips_pkg::word_t idex_rt_data;
	mips_pkg::word_t idex_imm;
	mips_pkg::reg_idx_t idex_rs;
	mips_pkg::reg_idx_t idex_rt;
	mips_pkg::reg_idx_t idex_dest;
	logic [4:0] idex_shamt;

	logic exmem_reg_write;
	logic exmem_mem_read;
	logic exmem_mem_write;
	logic exmem_mem_to_reg;
	mips_pkg::word_t exmem_result;
	mips_pkg::word_t exmem_store_data;
	mips_pkg::reg_idx_t exmem_dest;

	logic wb_reg_write;
	mips_pkg::reg_idx_t wb_dest;
	mips_pkg::word_t wb_data;

	// stage ports share names with the wires above
	fetch_stage fetch_i (.*);
	hazard_unit hazard_i (.*);
	decode_stage decode_i (.*);
	execute_stage execute_i (.*);
	mem_wb_stage mem_wb_i (.*);

	assign dmem_addr = exmem_result[mips_pkg::DMEM_AW-1:0]; // word address
	assign dmem_wdata = exmem_store_data;
	assign dmem_we = exmem_mem_write;
	assign dmem_re = exmem_mem_read;

endmodule

`default_nettype wire

/* src/mem_wb_stage.sv */
//##############################
// Memory / write-back stage
// MEM/WB register and result mux
//##############################
`timescale 1ns/1ns
`default_nettype none

module mem_wb_stage (
	input wire clk,
	input wire rst_n,
	input wire exmem_reg_write,
	input wire exmem_mem_to_reg,
	input wire mips_pkg::word_t exmem_result,
	input wire mips_pkg::reg_idx_t exmem_dest,
	input wire mips_pkg::word_t dmem_rdata,
	output logic wb_reg_write,
	output mips_pkg::reg_idx_t wb_dest,
	output mips_pkg::word_t wb_data
);

	logic mem_to_reg_q;
	mips_pkg::word_t load_q;
	mips_pkg::word_t result_q;

	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			wb_reg_write <= 1'b0;
			mem_to_reg_q <= 1'b0;
		end
		else
		begin
			wb_reg_write <= exmem_reg_write;
			mem_to_reg_q <= exmem_mem_to_reg;
		end
	end

	always_ff @(posedge clk)
	begin
		load_q <= dmem_rdata; // read data settles within the MEM cycle
		result_q <= exmem_result;
		wb_dest <= exmem_dest;
	end

	assign wb_data = mem_to_reg_q ? load_q : result_q;

endmodule

`default_nettype wire

/* src/execute_stage.sv */
//##############################
// Execute stage
// operand forwarding, ALU and
// the EX/MEM register
//##############################
`timescale 1ns/1ns
`default_nettype none

module execute_stage (
	input wire clk,
	input wire rst_n,
	input wire idex_reg_write,
	input wire idex_mem_read,
	input wire idex_mem_write,
	input wire idex_mem_to_reg,
	input wire idex_alu_src,
	input wire mips_pkg::alu_op_e idex_alu_op,
	input wire mips_pkg::word_t idex_rs_data,
	input wire mips_pkg::word_t idex_rt_data,
	input wire mips_pkg::word_t idex_imm,
	input wire mips_pkg::reg_idx_t idex_rs,
	input wire mips_pkg::reg_idx_t idex_rt,
	input wire mips_pkg::reg_idx_t idex_dest,
	input wire [4:0] idex_shamt,
	input wire mips_pkg::reg_idx_t wb_dest,
	input wire wb_reg_write,
	input wire mips_pkg::word_t wb_data,
	output logic exmem_reg_write,
	output logic exmem_mem_read,
	output logic exmem_mem_write,
	output logic exmem_mem_to_reg,
	output mips_pkg::word_t exmem_result,
	output mips_pkg::word_t exmem_store_data,
	output mips_pkg::reg_idx_t exmem_dest
);

	mips_pkg::fwd_sel_e sel_a;
	mips_pkg::fwd_sel_e sel_b;
	mips_pkg::word_t op_a;
	mips_pkg::word_t op_b;
	mips_pkg::word_t alu_b;
	mips_pkg::word_t alu_result;

	assign sel_a = mips_pkg::fwd_select(idex_rs, exmem_dest, exmem_reg_write,
		wb_dest, wb_reg_write);
	assign sel_b = mips_pkg::fwd_select(idex_rt, exmem_dest, exmem_reg_write,
		wb_dest, wb_reg_write);

	assign op_a = (sel_a == mips_pkg::FWD_EXMEM) ? exmem_result :
		(sel_a == mips_pkg::FWD_MEMWB) ? wb_data : idex_rs_data;
	assign op_b = (sel_b == mips_pkg::FWD_EXMEM) ? exmem_result :
		(sel_b == mips_pkg::FWD_MEMWB) ? wb_data : idex_rt_data;
	assign alu_b = idex_alu_src ? idex_imm : op_b;

	always_comb
	begin
		case (idex_alu_op)
			mips_pkg::ALU_AND: alu_result = op_a & alu_b;
			mips_pkg::ALU_OR: alu_result = op_a | alu_b;
			mips_pkg::ALU_ADD: alu_result = op_a + alu_b;
			mips_pkg::ALU_SUB: alu_result = op_a - alu_b;
			mips_pkg::ALU_XOR: alu_result = op_a ^ alu_b;
			mips_pkg::ALU_NOR: alu_result = ~(op_a | alu_b);
			mips_pkg::ALU_SLT: alu_result = {31'd0, $signed(op_a) < $signed(alu_b)}; // signed
			mips_pkg::ALU_SLL: alu_result = alu_b << idex_shamt; // shifts act on rt
			mips_pkg::ALU_SRL: alu_result = alu_b >> idex_shamt;
			mips_pkg::ALU_LUI: alu_result = {alu_b[15:0], 16'd0};
			default: alu_result = '0;
		endcase
	end

	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			exmem_reg_write <= 1'b0;
			exmem_mem_read <= 1'b0;
			exmem_mem_write <= 1'b0;
			exmem_mem_to_reg <= 1'b0;
		end
		else
		begin
			exmem_reg_write <= idex_reg_write;
			exmem_mem_read <= idex_mem_read;
			exmem_mem_write <= idex_mem_write;
			exmem_mem_to_reg <= idex_mem_to_reg;
		end
	end

	always_ff @(posedge clk)
	begin
		exmem_result <= alu_result;
		exmem_store_data <= op_b; // forwarded rt for sw
		exmem_dest <= idex_dest;
	end

endmodule

`default_nettype wire

/* src/decode_stage.sv */
//##############################
// Decode stage
// register file, control, branch
// compare and the ID/EX register
//##############################
`timescale 1ns/1ns
`default_nettype none

module decode_stage (
	input wire clk,
	input wire rst_n,
	input wire mips_pkg::word_t ifid_instr,
	input wire mips_pkg::pc_t ifid_pc_next,
	input wire bubble,
	input wire mips_pkg::reg_idx_t exmem_dest,
	input wire exmem_reg_write,
	input wire mips_pkg::word_t exmem_result,
	input wire mips_pkg::reg_idx_t wb_dest,
	input wire wb_reg_write,
	input wire mips_pkg::word_t wb_data,
	output logic branch_taken,
	output mips_pkg::pc_t branch_target,
	output logic idex_reg_write,
	output logic idex_mem_read,
	output logic idex_mem_write,
	output logic idex_mem_to_reg,
	output logic idex_alu_src,
	output mips_pkg::alu_op_e idex_alu_op,
	output mips_pkg::word_t idex_rs_data,
	output mips_pkg::word_t idex_rt_data,
	output mips_pkg::word_t idex_imm,
	output mips_pkg::reg_idx_t idex_rs,
	output mips_pkg::reg_idx_t idex_rt,
	output mips_pkg::reg_idx_t idex_dest,
	output logic [4:0] idex_shamt
);

	logic [5:0] opcode;
	logic [5:0] funct;
	mips_pkg::reg_idx_t rs;
	mips_pkg::reg_idx_t rt;
	mips_pkg::word_t regs [32];
	mips_pkg::word_t rs_val;
	mips_pkg::word_t rt_val;
	mips_pkg::fwd_sel_e sel_a;
	mips_pkg::fwd_sel_e sel_b;
	mips_pkg::word_t cmp_a;
	mips_pkg::word_t cmp_b;
	mips_pkg::word_t imm;
	mips_pkg::alu_op_e alu_op;
	logic reg_write;
	logic mem_read;
	logic mem_write;
	logic mem_to_reg;
	logic alu_src;
	logic reg_dst;
	logic zero_ext;

	assign opcode = ifid_instr[31:26];
	assign funct = ifid_instr[5:0];
	assign rs = ifid_instr[25:21];
	assign rt = ifid_instr[20:16];

	// r29 comes up as the stack pointer
	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			for (int i = 0; i < 32; i++)
				regs[i] <= (i == mips_pkg::SP_REG) ? mips_pkg::SP_RESET : 32'd0;
		end
		else if (wb_reg_write && wb_dest != '0)
			regs[wb_dest] <= wb_data;
	end

	// same-cycle write shows through on read
	assign rs_val = (wb_reg_write && wb_dest != '0 && wb_dest == rs) ? wb_data : regs[rs];
	assign rt_val = (wb_reg_write && wb_dest != '0 && wb_dest == rt) ? wb_data : regs[rt];

	assign sel_a = mips_pkg::fwd_select(rs, exmem_dest, exmem_reg_write, wb_dest, wb_reg_write);
	assign sel_b = mips_pkg::fwd_select(rt, exmem_dest, exmem_reg_write, wb_dest, wb_reg_write);
	// write-back data reaches the compare through the bypassed reads
	assign cmp_a = (sel_a == mips_pkg::FWD_EXMEM) ? exmem_result : rs_val;
	assign cmp_b = (sel_b == mips_pkg::FWD_EXMEM) ? exmem_result : rt_val;

	assign branch_taken = (opcode == mips_pkg::OP_BEQ && cmp_a == cmp_b) ||
		(opcode == mips_pkg::OP_BNE && cmp_a != cmp_b);

	assign imm = zero_ext ? {16'd0, ifid_instr[15:0]} : {{16{ifid_instr[15]}}, ifid_instr[15:0]};
	assign branch_target = ifid_pc_next + imm; // offset in words from pc+1

	always_comb
	begin
		reg_write = 1'b0;
		mem_read = 1'b0;
		mem_write = 1'b0;
		mem_to_reg = 1'b0;
		alu_src = 1'b1;
		reg_dst = 1'b0;
		zero_ext = 1'b0;
		alu_op = mips_pkg::ALU_ADD; // lw, sw and addi address add
		case (opcode)
			mips_pkg::OP_RTYPE:
			begin
				reg_write = 1'b1;
				alu_src = 1'b0;
				reg_dst = 1'b1;
				case (funct)
					mips_pkg::FN_SLL: alu_op = mips_pkg::ALU_SLL;
					mips_pkg::FN_SRL: alu_op = mips_pkg::ALU_SRL;
					mips_pkg::FN_ADD: alu_op = mips_pkg::ALU_ADD;
					mips_pkg::FN_SUB: alu_op = mips_pkg::ALU_SUB;
					mips_pkg::FN_AND: alu_op = mips_pkg::ALU_AND;
					mips_pkg::FN_OR: alu_op = mips_pkg::ALU_OR;
					mips_pkg::FN_XOR: alu_op = mips_pkg::ALU_XOR;
					mips_pkg::FN_NOR: alu_op = mips_pkg::ALU_NOR;
					mips_pkg::FN_SLT: alu_op = mips_pkg::ALU_SLT;
					default: reg_write = 1'b0; // unsupported function, no effect
				endcase
			end
			mips_pkg::OP_ADDI: reg_write = 1'b1;
			mips_pkg::OP_SLTI:
			begin
				reg_write = 1'b1;
				alu_op = mips_pkg::ALU_SLT;
			end
			mips_pkg::OP_ANDI:
			begin
				reg_write = 1'b1;
				alu_op = mips_pkg::ALU_AND;
			end
			mips_pkg::OP_ORI:
			begin
				reg_write = 1'b1;
				zero_ext = 1'b1; // only ori zero-extends
				alu_op = mips_pkg::ALU_OR;
			end
			mips_pkg::OP_LUI:
			begin
				reg_write = 1'b1;
				alu_op = mips_pkg::ALU_LUI;
			end
			mips_pkg::OP_LW:
			begin
				reg_write = 1'b1;
				mem_read = 1'b1;
				mem_to_reg = 1'b1;
			end
			mips_pkg::OP_SW: mem_write = 1'b1;
			default: alu_src = 1'b0; // branches write nothing
		endcase
	end

	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			idex_reg_write <= 1'b0;
			idex_mem_read <= 1'b0;
			idex_mem_write <= 1'b0;
			idex_mem_to_reg <= 1'b0;
			idex_alu_src <= 1'b0;
			idex_alu_op <= mips_pkg::ALU_ADD;
		end
		else
		begin
			idex_reg_write <= reg_write && !bubble;
			idex_mem_read <= mem_read && !bubble;
			idex_mem_write <= mem_write && !bubble;
			idex_mem_to_reg <= mem_to_reg;
			idex_alu_src <= alu_src;
			idex_alu_op <= alu_op;
		end
	end

	always_ff @(posedge clk)
	begin
		idex_rs_data <= rs_val;
		idex_rt_data <= rt_val;
		idex_imm <= imm;
		idex_rs <= rs;
		idex_rt <= rt;
		idex_dest <= reg_dst ? ifid_instr[15:11] : rt; // rd for R-type
		idex_shamt <= ifid_instr[10:6];
	end

endmodule

`default_nettype wire

/* src/hazard_unit.sv */
//##############################
// Hazard unit
// load-use and branch operand
// stalls, wrong-path flush
//##############################
`timescale 1ns/1ns
`default_nettype none

module hazard_unit (
	input wire mips_pkg::word_t ifid_instr,
	input wire idex_mem_read,
	input wire idex_reg_write,
	input wire mips_pkg::reg_idx_t idex_dest,
	input wire exmem_mem_read,
	input wire mips_pkg::reg_idx_t exmem_dest,
	input wire branch_taken,
	output logic hold,
	output logic bubble,
	output logic flush
);

	logic [5:0] opcode;
	mips_pkg::reg_idx_t rs;
	mips_pkg::reg_idx_t rt;
	logic is_branch;
	logic uses_rt;
	logic ex_match;
	logic mem_match;
	logic load_use;
	logic branch_wait;

	assign opcode = ifid_instr[31:26];
	assign rs = ifid_instr[25:21];
	assign rt = ifid_instr[20:16];

	assign is_branch = (opcode == mips_pkg::OP_BEQ) || (opcode == mips_pkg::OP_BNE);
	assign uses_rt = (opcode == mips_pkg::OP_RTYPE) || is_branch || (opcode == mips_pkg::OP_SW);

	assign ex_match = (idex_dest != '0) && ((idex_dest == rs) || (uses_rt && idex_dest == rt));
	assign mem_match = (exmem_dest != '0) && ((exmem_dest == rs) || (uses_rt && exmem_dest == rt));

	assign load_use = idex_mem_read && ex_match;
	// compare sits in decode: wait out EX results and loads still in MEM
	assign branch_wait = is_branch && ((idex_reg_write && ex_match) || (exmem_mem_read && mem_match));

	assign hold = load_use || branch_wait;
	assign bubble = hold; // stalled decode sends a no-op down
	assign flush = branch_taken && !hold;

endmodule

`default_nettype wire

/* src/fetch_stage.sv */
//##############################
// Fetch stage
// PC, next-PC choice and the
// IF/ID register
//##############################
`timescale 1ns/1ns
`default_nettype none

module fetch_stage (
	input wire clk,
	input wire rst_n,
	input wire hold,
	input wire flush,
	input wire branch_taken,
	input wire mips_pkg::pc_t branch_target,
	input wire mips_pkg::word_t imem_data,
	output mips_pkg::pc_t imem_addr,
	output mips_pkg::word_t ifid_instr,
	output mips_pkg::pc_t ifid_pc_next
);

	mips_pkg::pc_t pc;
	mips_pkg::pc_t pc_plus1;

	assign pc_plus1 = pc + 32'd1; // one word per instruction
	assign imem_addr = pc;

	always_ff @(posedge clk)
	begin
		if (!rst_n)
			pc <= '0;
		else if (!hold)
			pc <= branch_taken ? branch_target : pc_plus1;
	end

	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			ifid_instr <= '0;
			ifid_pc_next <= '0;
		end
		else if (!hold)
		begin
			ifid_instr <= flush ? 32'd0 : imem_data; // all zero decodes as sll r0, a no-op
			ifid_pc_next <= pc_plus1;
		end
	end

endmodule

`default_nettype wire

/* src/mips_pkg.sv */
//##############################
// MIPS pipeline shared types
// word formats, encodings, ALU ops
// and forwarding selects
//##############################
`default_nettype none

package mips_pkg;

	typedef logic [31:0] word_t;
	typedef logic [4:0] reg_idx_t;
	typedef logic [31:0] pc_t; // counts words, not bytes

	localparam int DMEM_AW = 13; // data word address bits
	localparam reg_idx_t SP_REG = 5'd29;
	localparam word_t SP_RESET = 32'h00001FFF; // top of data memory

	localparam logic [5:0] OP_RTYPE = 6'd0;
	localparam logic [5:0] OP_BEQ = 6'd4;
	localparam logic [5:0] OP_BNE = 6'd5;
	localparam logic [5:0] OP_ADDI = 6'd8;
	localparam logic [5:0] OP_SLTI = 6'd10;
	localparam logic [5:0] OP_ANDI = 6'd12;
	localparam logic [5:0] OP_ORI = 6'd13;
	localparam logic [5:0] OP_LUI = 6'd15;
	localparam logic [5:0] OP_LW = 6'd35;
	localparam logic [5:0] OP_SW = 6'd43;

	localparam logic [5:0] FN_SLL = 6'h00;
	localparam logic [5:0] FN_SRL = 6'h02;
	localparam logic [5:0] FN_ADD = 6'h20;
	localparam logic [5:0] FN_SUB = 6'h22;
	localparam logic [5:0] FN_AND = 6'h24;
	localparam logic [5:0] FN_OR = 6'h25;
	localparam logic [5:0] FN_XOR = 6'h26;
	localparam logic [5:0] FN_NOR = 6'h27;
	localparam logic [5:0] FN_SLT = 6'h2a;

	typedef enum logic [3:0] {
		ALU_AND, ALU_OR, ALU_ADD, ALU_SUB, ALU_XOR,
		ALU_NOR, ALU_SLT, ALU_SLL, ALU_SRL, ALU_LUI
	} alu_op_e;

	typedef enum logic [1:0] {FWD_NONE, FWD_EXMEM, FWD_MEMWB} fwd_sel_e;

	// newest producer wins, r0 is never forwarded
	function automatic fwd_sel_e fwd_select(
		input reg_idx_t src,
		input reg_idx_t exmem_dest,
		input logic exmem_we,
		input reg_idx_t wb_dest,
		input logic wb_we
	);
		if (src == '0)
			return FWD_NONE;
		if (exmem_we && exmem_dest == src)
			return FWD_EXMEM;
		if (wb_we && wb_dest == src)
			return FWD_MEMWB;
		return FWD_NONE;
	endfunction

endpackage

`default_nettype wire
